/* verilog.f */
+incdir+hw
hw/prbs_bist_pkg.sv
hw/prbs_cfg_regs.sv
hw/rx_bit_select.sv
hw/prbs_generator.sv
hw/prbs_checker.sv
hw/prbs_bist_top.sv
verif/prbs_bist_monitor.sv
verif/prbs_bist_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing -j 0 --top-module prbs_bist_tb -f verilog.f -o prbs_bist_sim && \
./obj_dir/prbs_bist_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" && \
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verif/prbs_bist_tb.sv */
`timescale 1ns/1ps
`include "prbs_bist_consts.svh"

module prbs_bist_tb;
    import prbs_bist_pkg::*;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_RUN,
        OP_RUN_ADC
    } op_t;

    typedef struct packed {
        op_t         op;
        reg_addr_t   addr;
        logic [31:0] data;
        logic [31:0] count;
        logic [31:0] expected;
    } step_t;

    logic             clk_adc;
    logic             rst_n;
    lane_codes_t      adc_codes;
    logic             cfg_we;
    reg_addr_t        cfg_addr;
    logic [`NCFG-1:0] cfg_wdata;
    logic [`NCFG-1:0] cfg_rdata;
    logic             err_flag;
    logic             exp_valid;
    logic [31:0]      exp_data;
    logic             done;
    logic [31:0]      flag_expected;
    logic [31:0]      cycle_limit;
    int               error_count;
    int               check_count;
    logic             timed_out;

    step_t steps[$];

    // reference model of the register and counter rules
    src_sel_t         m_src;
    chk_mode_t        m_mode;
    logic signed [7:0] m_thresh;
    lane_bits_t       m_inv;
    lane_bits_t       m_sel;
    logic [31:0]      m_eqn;
    logic [31:0]      m_err;
    logic [31:0]      m_total;
    int               m_flags;
    lane_bits_t       code_inv;
    logic [6:0]       prbs_p;
    logic [31:0]      lcg_state;

    prbs_bist_top DUT (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n),
        .adc_codes_i (adc_codes),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .err_flag_o  (err_flag)
    );

    prbs_bist_monitor monitor (
        .clk_i           (clk_adc),
        .rst_n_i         (rst_n),
        .cfg_rdata_i     (cfg_rdata),
        .err_flag_i      (err_flag),
        .exp_valid_i     (exp_valid),
        .exp_data_i      (exp_data),
        .done_i          (done),
        .flag_expected_i (flag_expected),
        .cycle_limit_i   (cycle_limit),
        .error_count_o   (error_count),
        .check_count_o   (check_count),
        .timeout_o       (timed_out)
    );

    initial begin
        clk_adc = 1'b0;
        forever #10 clk_adc = ~clk_adc;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int ones(input logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n = n + int'(v[i]);
        end
        return n;
    endfunction

    function automatic logic [31:0] ctrl_word(input src_sel_t s, input chk_mode_t m,
                                              input logic cke);
        return {28'd0, cke, m, s};
    endfunction

    task automatic add_step(input op_t op, input reg_addr_t a, input logic [31:0] d,
                            input logic [31:0] n, input logic [31:0] e);
        step_t st;
        st.op       = op;
        st.addr     = a;
        st.data     = d;
        st.count    = n;
        st.expected = e;
        steps.push_back(st);
    endtask

    task automatic write_step(input reg_addr_t a, input logic [31:0] d);
        add_step(OP_WRITE, a, d, 32'd1, 32'd0);
    endtask

    task automatic read_step(input reg_addr_t a, input logic [31:0] e);
        add_step(OP_READ, a, 32'd0, 32'd1, e);
    endtask

    task automatic build_table;
        // reset values
        read_step(REG_CTRL, 32'd0);
        read_step(REG_THRESH, 32'd0);
        read_step(REG_INV, 32'd0);
        read_step(REG_CHAN_SEL, 32'd0);
        read_step(REG_EQN, 32'h60);
        read_step(REG_GEN_INIT, 32'd0);
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        write_step(REG_THRESH, 32'd20);
        write_step(REG_INV, 32'ha);
        write_step(REG_CHAN_SEL, 32'h5);
        write_step(REG_EQN, 32'h41);
        write_step(REG_GEN_INIT, 32'h7f);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_ALIGN, 1'b0));
        write_step(REG_ERR_CNT, 32'hdead);
        write_step(REG_TOTAL_CNT, 32'hbeef);
        read_step(REG_THRESH, 32'd20);
        read_step(REG_INV, 32'ha);
        read_step(REG_CHAN_SEL, 32'h5);
        read_step(REG_EQN, 32'h41);
        read_step(REG_GEN_INIT, 32'h7f);
        read_step(REG_CTRL, 32'h2);
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        // back to the prbs7 taps
        write_step(REG_EQN, 32'h60);
        // clean bist run over all lanes
        write_step(REG_INV, 32'd0);
        write_step(REG_CHAN_SEL, 32'hf);
        write_step(REG_GEN_INIT, 32'h1);
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_ALIGN, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd40, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_COUNT, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd99, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_HOLD, 1'b1));
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        // two injected errors spaced past the tap depth
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_CLEAR, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd40, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_COUNT, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd5, 32'd0);
        write_step(REG_INJ, 32'd1);
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd20, 32'd0);
        write_step(REG_INJ, 32'd1);
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd20, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_BIST, CHK_HOLD, 1'b1));
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        // plain adc codes under an inversion mask on lanes 0 and 1
        write_step(REG_INV, 32'h3);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_CLEAR, 1'b1));
        add_step(OP_RUN_ADC, REG_CTRL, 32'h0, 32'd40, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_COUNT, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd49, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_HOLD, 1'b1));
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        // same mask with codes inverted to match
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_CLEAR, 1'b1));
        add_step(OP_RUN_ADC, REG_CTRL, 32'h3, 32'd40, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_COUNT, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd49, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_HOLD, 1'b1));
        read_step(REG_CTRL, 32'he);
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        // mismatched lanes 1 and 3 deselected before the clear
        write_step(REG_CHAN_SEL, 32'h5);
        write_step(REG_INV, 32'h9);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_CLEAR, 1'b1));
        add_step(OP_RUN_ADC, REG_CTRL, 32'h3, 32'd40, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_COUNT, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd29, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_HOLD, 1'b1));
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
        write_step(REG_CTRL, ctrl_word(SRC_ADC, CHK_CLEAR, 1'b1));
        add_step(OP_RUN, REG_CTRL, 32'd0, 32'd2, 32'd0);
        read_step(REG_ERR_CNT, 32'd0);
        read_step(REG_TOTAL_CNT, 32'd0);
    endtask

    // prbs7 bit steers each code above or below the threshold
    task automatic drive_codes;
        logic       bit_v;
        logic [6:0] mag;
        bit_v  = prbs_p[6] ^ prbs_p[5];
        prbs_p = {prbs_p[5:0], bit_v};
        for (int i = 0; i < `NTI; i++) begin
            lcg_state = lcg_next(lcg_state);
            mag       = lcg_state[30:24] % 7'd100;
            if (bit_v ^ code_inv[i]) begin
                adc_codes[i] = m_thresh + 8'sd1 + $signed({1'b0, mag});
            end else begin
                adc_codes[i] = m_thresh - $signed({1'b0, mag});
            end
        end
    endtask

    // counting uses the settings in force before this edge's write
    task automatic model_edge(input logic wr, input reg_addr_t a, input logic [31:0] d);
        int bad;
        bad = 0;
        if (m_mode == CHK_COUNT) begin
            m_total = m_total + 32'(ones(32'(m_sel)));
            if (m_src == SRC_ADC) begin
                bad = ones(32'(m_sel & (m_inv ^ code_inv)));
            end else begin
                bad = ones(32'(m_sel & m_inv));
            end
            m_err = m_err + 32'(bad);
            if (bad != 0) begin
                m_flags = m_flags + 1;
            end
        end else if (m_mode == CHK_CLEAR) begin
            m_err   = '0;
            m_total = '0;
        end
        if (wr) begin
            case (a)
                REG_CTRL: begin
                    m_src  = src_sel_t'(d[0]);
                    m_mode = chk_mode_t'(d[2:1]);
                end
                REG_THRESH:   m_thresh = d[7:0];
                REG_INV:      m_inv = d[3:0];
                REG_CHAN_SEL: m_sel = d[3:0];
                REG_EQN:      m_eqn = d;
                REG_INJ: begin
                    // one bad bit and once more per tap that sees it
                    if (m_mode == CHK_COUNT) begin
                        m_err   = m_err + 32'((1 + ones(m_eqn)) * ones(32'(m_sel)));
                        m_flags = m_flags + 1 + ones(m_eqn);
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic do_cycle(input logic we, input reg_addr_t a, input logic [31:0] d,
                            input logic ev, input logic [31:0] ed);
        @(negedge clk_adc);
        cfg_we    = we;
        cfg_addr  = a;
        cfg_wdata = d;
        exp_valid = ev;
        exp_data  = ed;
        drive_codes();
        @(posedge clk_adc);
        model_edge(we, a, d);
    endtask

    initial begin
        int          total;
        logic [31:0] expv;
        rst_n         = 1'b0;
        cfg_we        = 1'b0;
        cfg_addr      = REG_CTRL;
        cfg_wdata     = '0;
        adc_codes     = '0;
        exp_valid     = 1'b0;
        exp_data      = '0;
        done          = 1'b0;
        flag_expected = '0;
        m_src         = SRC_ADC;
        m_mode        = CHK_CLEAR;
        m_thresh      = '0;
        m_inv         = '0;
        m_sel         = '0;
        m_eqn         = 32'h60;
        m_err         = '0;
        m_total       = '0;
        m_flags       = 0;
        code_inv      = '0;
        prbs_p        = 7'h01;
        lcg_state     = 32'h93ee_e41b;
        build_table();
        total = 0;
        foreach (steps[i]) begin
            total = total + int'(steps[i].count);
        end
        cycle_limit = 32'(total + 10 + 200);
        repeat (2) @(posedge clk_adc);
        @(negedge clk_adc);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: do_cycle(1'b1, steps[i].addr, steps[i].data, 1'b0, 32'd0);
                OP_READ: begin
                    if (steps[i].addr == REG_ERR_CNT) begin
                        expv = m_err;
                    end else if (steps[i].addr == REG_TOTAL_CNT) begin
                        expv = m_total;
                    end else begin
                        expv = steps[i].expected;
                    end
                    do_cycle(1'b0, steps[i].addr, 32'd0, 1'b1, expv);
                end
                default: begin
                    if (steps[i].op == OP_RUN_ADC) begin
                        code_inv = steps[i].data[3:0];
                    end
                    repeat (steps[i].count) do_cycle(1'b0, REG_CTRL, 32'd0, 1'b0, 32'd0);
                end
            endcase
        end
        repeat (5) do_cycle(1'b0, REG_CTRL, 32'd0, 1'b0, 32'd0);
        @(negedge clk_adc);
        flag_expected = 32'(m_flags);
        done          = 1'b1;
        @(posedge clk_adc);
        @(negedge clk_adc);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge timed_out) begin
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verif/prbs_bist_monitor.sv */
`timescale 1ns/1ps

module prbs_bist_monitor (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] cfg_rdata_i,
    input  logic        err_flag_i,
    input  logic        exp_valid_i,
    input  logic [31:0] exp_data_i,
    input  logic        done_i,
    input  logic [31:0] flag_expected_i,
    input  logic [31:0] cycle_limit_i,
    output int          error_count_o,
    output int          check_count_o,
    output logic        timeout_o
);
    int          errors = 0;
    int          checks = 0;
    int          flag_cycles = 0;
    int          cycle_count = 0;
    logic        timed_out = 1'b0;
    logic        final_done = 1'b0;
    logic        pending_q = 1'b0;
    logic [31:0] pending_data_q = '0;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        // readback lags the address by one edge
        if (pending_q) begin
            checks = checks + 1;
            if (cfg_rdata_i !== pending_data_q) begin
                errors = errors + 1;
                $display("[ERROR] %0t cfg_rdata_o expected %h got %h",
                         $time, pending_data_q, cfg_rdata_i);
            end
        end
        pending_q      = exp_valid_i;
        pending_data_q = exp_data_i;
        if (rst_n_i && err_flag_i === 1'b1) begin
            flag_cycles = flag_cycles + 1;
        end
        if (done_i && !final_done) begin
            final_done = 1'b1;
            checks     = checks + 1;
            if (flag_cycles != int'(flag_expected_i)) begin
                errors = errors + 1;
                $display("[ERROR] %0t err_flag_o high cycles expected %0d got %0d",
                         $time, flag_expected_i, flag_cycles);
            end
        end
        if (cycle_limit_i != 0 && cycle_count >= int'(cycle_limit_i) && !timed_out) begin
            timed_out = 1'b1;
            $display("run timed out after %0d cycles before the stimulus table finished",
                     cycle_count);
        end
    end

    assign error_count_o = errors;
    assign check_count_o = checks;
    assign timeout_o     = timed_out;

endmodule

/* hw/prbs_bist_top.sv */
`timescale 1ns/1ps
`include "prbs_bist_consts.svh"

module prbs_bist_top (
    input  logic                       clk_adc,
    input  logic                       rst_n_i,
    input  prbs_bist_pkg::lane_codes_t adc_codes_i,
    input  logic                       cfg_we_i,
    input  prbs_bist_pkg::reg_addr_t   cfg_addr_i,
    input  logic [`NCFG-1:0]           cfg_wdata_i,
    output logic [`NCFG-1:0]           cfg_rdata_o,
    output logic                       err_flag_o
);
    import prbs_bist_pkg::*;

    prbs_cfg_t    cfg;
    prbs_counts_t counts;
    lane_bits_t   rx_bits;
    logic         bist_bit;

    prbs_cfg_regs cfg_regs_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .counts_i    (counts),
        .cfg_o       (cfg),
        .cfg_rdata_o (cfg_rdata_o)
    );

    // bist source for the receive mux
    prbs_generator prbs_gen_i (
        .clk_adc (clk_adc),
        .rst_n_i (rst_n_i),
        .cfg_i   (cfg),
        .bit_o   (bist_bit)
    );

    rx_bit_select rx_sel_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .adc_codes_i (adc_codes_i),
        .bist_bit_i  (bist_bit),
        .cfg_i       (cfg),
        .rx_bits_o   (rx_bits)
    );

    prbs_checker prbs_chk_i (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .rx_bits_i  (rx_bits),
        .cfg_i      (cfg),
        .counts_o   (counts),
        .err_flag_o (err_flag_o)
    );

endmodule

/* hw/prbs_checker.sv */
`timescale 1ns/1ps
`include "prbs_bist_consts.svh"

module prbs_checker (
    input  logic                        clk_adc,
    input  logic                        rst_n_i,
    input  prbs_bist_pkg::lane_bits_t   rx_bits_i,
    input  prbs_bist_pkg::prbs_cfg_t    cfg_i,
    output prbs_bist_pkg::prbs_counts_t counts_o,
    output logic                        err_flag_o
);
    import prbs_bist_pkg::*;

    // bit i holds the lane bit from i+1 cycles ago
    prbs_word_t         hist_q [`NTI];
    lane_bits_t         predicted;
    lane_bits_t         err_bits;
    logic [`NCOUNT-1:0] err_inc;
    logic [`NCOUNT-1:0] sel_inc;
    logic               shift_en;
    prbs_counts_t       counts_q;
    logic               err_flag_q;

    always_comb begin
        err_inc = '0;
        sel_inc = '0;
        for (int i = 0; i < `NTI; i++) begin
            predicted[i] = ^(hist_q[i] & cfg_i.eqn);
            err_bits[i]  = (rx_bits_i[i] ^ predicted[i]) & cfg_i.chan_sel[i];
            err_inc      = err_inc + `NCOUNT'(err_bits[i]);
            sel_inc      = sel_inc + `NCOUNT'(cfg_i.chan_sel[i]);
        end
    end

    // histories run in every mode but hold
    assign shift_en = (cfg_i.chk_mode != CHK_HOLD);

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NTI; i++) begin
                hist_q[i] <= '0;
            end
        end else if (shift_en) begin
            for (int i = 0; i < `NTI; i++) begin
                hist_q[i] <= {hist_q[i][`NPRBS-2:0], rx_bits_i[i]};
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            counts_q   <= '0;
            err_flag_q <= 1'b0;
        end else begin
            err_flag_q <= 1'b0;
            case (cfg_i.chk_mode)
                CHK_CLEAR: begin
                    counts_q <= '0;
                end
                CHK_COUNT: begin
                    counts_q.err_count   <= counts_q.err_count + err_inc;
                    counts_q.total_count <= counts_q.total_count + sel_inc;
                    err_flag_q           <= |err_bits;
                end
                // align and hold leave the counts alone
                default: begin
                    counts_q <= counts_q;
                end
            endcase
        end
    end

    assign counts_o   = counts_q;
    assign err_flag_o = err_flag_q;

endmodule

/* hw/prbs_generator.sv */
`timescale 1ns/1ps
`include "prbs_bist_consts.svh"

module prbs_generator (
    input  logic                     clk_adc,
    input  logic                     rst_n_i,
    input  prbs_bist_pkg::prbs_cfg_t cfg_i,
    output logic                     bit_o
);
    import prbs_bist_pkg::*;

    prbs_word_t state_q;
    logic       feedback;
    logic       bit_q;

    // parity over the tapped state bits
    assign feedback = ^(state_q & cfg_i.eqn);

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            state_q <= {{(`NPRBS-1){1'b0}}, 1'b1};
            bit_q   <= 1'b0;
        end else if (cfg_i.gen_load) begin
            state_q <= cfg_i.gen_init;
        end else if (cfg_i.gen_cke) begin
            // newest bit enters at the bottom
            state_q <= {state_q[`NPRBS-2:0], feedback};
            // injected flip reaches the output only, state stays clean
            bit_q   <= feedback ^ cfg_i.inj_err;
        end
    end

    assign bit_o = bit_q;

endmodule

/* hw/rx_bit_select.sv */
`timescale 1ns/1ps

module rx_bit_select (
    input  logic                       clk_adc,
    input  logic                       rst_n_i,
    input  prbs_bist_pkg::lane_codes_t adc_codes_i,
    input  logic                       bist_bit_i,
    input  prbs_bist_pkg::prbs_cfg_t   cfg_i,
    output prbs_bist_pkg::lane_bits_t  rx_bits_o
);
    import prbs_bist_pkg::*;

    lane_bits_t sliced;
    lane_bits_t rx_next;
    lane_bits_t rx_q;

    always_comb begin
        for (int i = 0; i < $bits(lane_bits_t); i++) begin
            // strictly above threshold reads as a one
            sliced[i] = $signed(adc_codes_i[i]) > $signed(cfg_i.thresh);
            if (cfg_i.src_sel == SRC_BIST) begin
                rx_next[i] = bist_bit_i ^ cfg_i.inv_mask[i];
            end else begin
                rx_next[i] = sliced[i] ^ cfg_i.inv_mask[i];
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            rx_q <= '0;
        end else begin
            rx_q <= rx_next;
        end
    end

    assign rx_bits_o = rx_q;

endmodule

/* hw/prbs_cfg_regs.sv */
`timescale 1ns/1ps
`include "prbs_bist_consts.svh"

module prbs_cfg_regs (
    input  logic                       clk_adc,
    input  logic                       rst_n_i,
    input  logic                       cfg_we_i,
    input  prbs_bist_pkg::reg_addr_t   cfg_addr_i,
    input  logic [`NCFG-1:0]           cfg_wdata_i,
    input  prbs_bist_pkg::prbs_counts_t counts_i,
    output prbs_bist_pkg::prbs_cfg_t   cfg_o,
    output logic [`NCFG-1:0]           cfg_rdata_o
);
    import prbs_bist_pkg::*;

    prbs_cfg_t        cfg_q;
    logic [`NCFG-1:0] rdata_mux;
    logic [`NCFG-1:0] rdata_q;

    // register writes, strobes drop after one cycle
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            cfg_q.src_sel  <= SRC_ADC;
            cfg_q.chk_mode <= CHK_CLEAR;
            cfg_q.gen_cke  <= 1'b0;
            cfg_q.thresh   <= '0;
            cfg_q.inv_mask <= '0;
            cfg_q.chan_sel <= '0;
            cfg_q.eqn      <= `PRBS7_EQN;
            cfg_q.gen_init <= '0;
            cfg_q.gen_load <= 1'b0;
            cfg_q.inj_err  <= 1'b0;
        end else begin
            cfg_q.gen_load <= 1'b0;
            cfg_q.inj_err  <= 1'b0;
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    REG_CTRL: begin
                        // bit 0 source, bits 2:1 mode, bit 3 generator enable
                        cfg_q.src_sel  <= src_sel_t'(cfg_wdata_i[0]);
                        cfg_q.chk_mode <= chk_mode_t'(cfg_wdata_i[2:1]);
                        cfg_q.gen_cke  <= cfg_wdata_i[3];
                    end
                    REG_THRESH: begin
                        cfg_q.thresh <= cfg_wdata_i[`NADC-1:0];
                    end
                    REG_INV: begin
                        cfg_q.inv_mask <= cfg_wdata_i[`NTI-1:0];
                    end
                    REG_CHAN_SEL: begin
                        cfg_q.chan_sel <= cfg_wdata_i[`NTI-1:0];
                    end
                    REG_EQN: begin
                        cfg_q.eqn <= cfg_wdata_i[`NPRBS-1:0];
                    end
                    REG_GEN_INIT: begin
                        cfg_q.gen_init <= cfg_wdata_i[`NPRBS-1:0];
                        cfg_q.gen_load <= 1'b1;
                    end
                    REG_INJ: begin
                        cfg_q.inj_err <= 1'b1;
                    end
                    // counter addresses are read only
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cfg_o = cfg_q;

    // readback select
    always_comb begin
        rdata_mux = '0;
        case (cfg_addr_i)
            REG_CTRL: begin
                rdata_mux[0]   = cfg_q.src_sel;
                rdata_mux[2:1] = cfg_q.chk_mode;
                rdata_mux[3]   = cfg_q.gen_cke;
            end
            REG_THRESH:    rdata_mux[`NADC-1:0]  = cfg_q.thresh;
            REG_INV:       rdata_mux[`NTI-1:0]   = cfg_q.inv_mask;
            REG_CHAN_SEL:  rdata_mux[`NTI-1:0]   = cfg_q.chan_sel;
            REG_EQN:       rdata_mux[`NPRBS-1:0] = cfg_q.eqn;
            REG_GEN_INIT:  rdata_mux[`NPRBS-1:0] = cfg_q.gen_init;
            REG_ERR_CNT:   rdata_mux[`NCOUNT-1:0] = counts_i.err_count;
            REG_TOTAL_CNT: rdata_mux[`NCOUNT-1:0] = counts_i.total_count;
            default:       rdata_mux = '0;
        endcase
    end

    // readback lags the address by one edge
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata_mux;
        end
    end

    assign cfg_rdata_o = rdata_q;

endmodule

/* hw/prbs_bist_pkg.sv */
`include "prbs_bist_consts.svh"

package prbs_bist_pkg;

    // one signed code per lane
    typedef logic signed [`NADC-1:0] adc_code_t;
    typedef adc_code_t [`NTI-1:0] lane_codes_t;

    // lane masks and receive bits
    typedef logic [`NTI-1:0] lane_bits_t;

    // lfsr state, tap mask or history
    typedef logic [`NPRBS-1:0] prbs_word_t;

    typedef enum logic {
        SRC_ADC,
        SRC_BIST
    } src_sel_t;

    typedef enum logic [1:0] {
        CHK_CLEAR,
        CHK_ALIGN,
        CHK_COUNT,
        CHK_HOLD
    } chk_mode_t;

    typedef enum logic [3:0] {
        REG_CTRL,
        REG_THRESH,
        REG_INV,
        REG_CHAN_SEL,
        REG_EQN,
        REG_GEN_INIT,
        REG_INJ,
        REG_ERR_CNT,
        REG_TOTAL_CNT
    } reg_addr_t;

    typedef struct packed {
        src_sel_t                src_sel;
        chk_mode_t               chk_mode;
        logic                    gen_cke;
        logic signed [`NADC-1:0] thresh;
        lane_bits_t              inv_mask;
        lane_bits_t              chan_sel;
        prbs_word_t              eqn;
        prbs_word_t              gen_init;
        // single-cycle strobes
        logic                    gen_load;
        logic                    inj_err;
    } prbs_cfg_t;

    typedef struct packed {
        logic [`NCOUNT-1:0] err_count;
        logic [`NCOUNT-1:0] total_count;
    } prbs_counts_t;

endpackage

/* hw/prbs_bist_consts.svh */
`ifndef PRBS_BIST_CONSTS_SVH
`define PRBS_BIST_CONSTS_SVH

// number of time-interleaved lanes
`define NTI 4

// signed adc code width
`define NADC 8

// lfsr state and checker history width
`define NPRBS 32

// error and total counter width
`define NCOUNT 32

// configuration data bus width
`define NCFG 32

// prbs7 taps, history bits 6 and 5
`define PRBS7_EQN 32'h0000_0060

`endif
